/* common/blimp_pkg.sv */
//--------------------------------------------------------------------------
// Shared constants for the blimp v1 core. Widths are fixed here, and the
// RTL takes no module parameters. Only ADD, ADDI and LUI are decoded.
//--------------------------------------------------------------------------

package blimp_pkg;

  //------------------------------------------------------------------------
  // Datapath and register file widths
  //------------------------------------------------------------------------

  // Data and address width
  localparam int XLEN = 32;

  // Register index width and entry count
  localparam int REG_ADDR_BITS = 5;
  localparam int NUM_REGS      = 2 ** REG_ADDR_BITS;

  //------------------------------------------------------------------------
  // Fetch
  //------------------------------------------------------------------------

  // Opaque tag echoed back by the memory
  localparam int SEQ_BITS = 5;

  // Max requests in flight
  localparam int FETCH_DEPTH = 2;

  // Counter wide enough to hold FETCH_DEPTH itself
  localparam int INFLIGHT_BITS = $clog2(FETCH_DEPTH + 1);

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0200;

  //------------------------------------------------------------------------
  // Instruction encodings
  //------------------------------------------------------------------------

  // Register-register ALU ops
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  // Register-immediate ALU ops
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  // Load upper immediate
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 shared by ADD and ADDI
  localparam logic [2:0] F3_ADD = 3'b000;

  // funct7 for ADD (SUB would set bit 5)
  localparam logic [6:0] F7_ADD = 7'b0000000;

endpackage

/* fetch/blimp_fetch.sv */
//--------------------------------------------------------------------------
// Fetch stage. Issues sequential requests from RESET_PC with a wrapping
// tag. Assumes at most one response per cycle and in-order returns.
// Request address and tag hold while a request waits for ready.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module blimp_fetch (
  input  logic                          clk,
  input  logic                          rst_n,
  output logic                          mem_req_val,
  input  logic                          mem_req_rdy,
  output logic [blimp_pkg::XLEN-1:0]     mem_req_addr,
  output logic [blimp_pkg::SEQ_BITS-1:0] mem_req_opaq,
  input  logic                          mem_resp_val
);

  import blimp_pkg::*;

  logic [XLEN-1:0]          pc;
  logic [SEQ_BITS-1:0]      tag;
  logic [INFLIGHT_BITS-1:0] inflight;
  logic [INFLIGHT_BITS-1:0] inflight_next;
  logic                     req_fire;

  // Request handshake completes this edge
  assign req_fire = mem_req_val && mem_req_rdy;

  //------------------------------------------------------------------------
  // In-flight credit counter
  //------------------------------------------------------------------------

  // Issue and return may land on the same edge
  always_comb begin
    inflight_next = inflight;
    case ({req_fire, mem_resp_val})
      2'b10:   inflight_next = inflight + 1'b1;
      2'b01:   inflight_next = inflight - 1'b1;
      default: inflight_next = inflight;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight <= '0;
    end else begin
      inflight <= inflight_next;
    end
  end

  //------------------------------------------------------------------------
  // Request valid, pc and tag
  //------------------------------------------------------------------------

  // Valid computed from next credit count so a freed slot is
  // reused on the following cycle. A stalled request keeps valid
  // high since the count cannot grow without a handshake.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_req_val <= 1'b0;
    end else begin
      mem_req_val <= (inflight_next < FETCH_DEPTH);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc  <= RESET_PC;
      tag <= '0;
    end else if (req_fire) begin
      // Next sequential word, tag wraps naturally
      pc  <= pc + 32'd4;
      tag <= tag + 1'b1;
    end
  end

  assign mem_req_addr = pc;
  assign mem_req_opaq = tag;

endmodule

/* src/blimp_regfile.sv */
//--------------------------------------------------------------------------
// Integer register file, 32 x 32. Two combinational reads, one write.
// x0 reads as zero and ignores writes.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module blimp_regfile (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [blimp_pkg::REG_ADDR_BITS-1:0] rs1_addr,
  input  logic [blimp_pkg::REG_ADDR_BITS-1:0] rs2_addr,
  output logic [blimp_pkg::XLEN-1:0]          rs1_data,
  output logic [blimp_pkg::XLEN-1:0]          rs2_data,
  input  logic                               wen,
  input  logic [blimp_pkg::REG_ADDR_BITS-1:0] waddr,
  input  logic [blimp_pkg::XLEN-1:0]          wdata
);

  import blimp_pkg::*;

  // Only x1..x31 have storage
  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Reads see the previous edge's write, no bypass
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* src/blimp_execute.sv */
//--------------------------------------------------------------------------
// Execute and retire. Decodes each response in its arrival cycle, writes
// the register file on that edge and registers one trace entry. Only ADD,
// ADDI and LUI write. Out-of-order tags set a sticky seq_err.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module blimp_execute (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               mem_resp_val,
  input  logic [blimp_pkg::XLEN-1:0]          mem_resp_data,
  input  logic [blimp_pkg::SEQ_BITS-1:0]      mem_resp_opaq,
  output logic [blimp_pkg::REG_ADDR_BITS-1:0] rs1_addr,
  output logic [blimp_pkg::REG_ADDR_BITS-1:0] rs2_addr,
  input  logic [blimp_pkg::XLEN-1:0]          rs1_data,
  input  logic [blimp_pkg::XLEN-1:0]          rs2_data,
  output logic                               rf_wen,
  output logic [blimp_pkg::REG_ADDR_BITS-1:0] rf_waddr,
  output logic [blimp_pkg::XLEN-1:0]          rf_wdata,
  output logic                               trace_val,
  output logic [blimp_pkg::XLEN-1:0]          trace_pc,
  output logic [blimp_pkg::REG_ADDR_BITS-1:0] trace_waddr,
  output logic [blimp_pkg::XLEN-1:0]          trace_wdata,
  output logic                               trace_wen,
  output logic                               seq_err
);

  import blimp_pkg::*;

  logic [XLEN-1:0]          pc;
  logic [SEQ_BITS-1:0]      exp_tag;
  logic                     tag_ok;
  logic                     retire;

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [REG_ADDR_BITS-1:0] rd;
  logic                     is_add;
  logic                     is_addi;
  logic                     is_lui;
  logic                     supported;
  logic                     writes_rd;
  logic [XLEN-1:0]          imm_i;
  logic [XLEN-1:0]          imm_u;
  logic [XLEN-1:0]          result;

  //------------------------------------------------------------------------
  // Decode
  //------------------------------------------------------------------------

  assign opcode   = mem_resp_data[6:0];
  assign rd       = mem_resp_data[11:7];
  assign funct3   = mem_resp_data[14:12];
  assign rs1_addr = mem_resp_data[19:15];
  assign rs2_addr = mem_resp_data[24:20];
  assign funct7   = mem_resp_data[31:25];

  // I-type sign extended, U-type upper 20 bits
  assign imm_i = {{(XLEN-12){mem_resp_data[31]}}, mem_resp_data[31:20]};
  assign imm_u = {mem_resp_data[31:12], 12'b0};

  assign is_add  = (opcode == OPC_OP) && (funct3 == F3_ADD) && (funct7 == F7_ADD);
  assign is_addi = (opcode == OPC_OP_IMM) && (funct3 == F3_ADD);
  assign is_lui  = (opcode == OPC_LUI);

  assign supported = is_add || is_addi || is_lui;
  // x0 destination counts as no write
  assign writes_rd = supported && (rd != '0);

  //------------------------------------------------------------------------
  // ALU
  //------------------------------------------------------------------------

  always_comb begin
    result = '0;
    if (is_add) begin
      result = rs1_data + rs2_data;
    end else if (is_addi) begin
      result = rs1_data + imm_i;
    end else if (is_lui) begin
      result = imm_u;
    end
  end

  //------------------------------------------------------------------------
  // Sequence check and retire
  //------------------------------------------------------------------------

  assign tag_ok = (mem_resp_opaq == exp_tag);
  // Mismatched responses are dropped entirely
  assign retire = mem_resp_val && tag_ok;

  assign rf_wen   = retire && writes_rd;
  assign rf_waddr = rd;
  assign rf_wdata = result;

  // pc and tag step on every response, so one bad tag
  // does not misalign the ones after it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= RESET_PC;
      exp_tag <= '0;
      seq_err <= 1'b0;
    end else if (mem_resp_val) begin
      pc      <= pc + 32'd4;
      exp_tag <= exp_tag + 1'b1;
      if (!tag_ok) begin
        seq_err <= 1'b1;
      end
    end
  end

  // Trace valid pulses one cycle after the response edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trace_val <= 1'b0;
    end else begin
      trace_val <= retire;
    end
  end

  // Trace payload, only meaningful with trace_val
  always_ff @(posedge clk) begin
    if (retire) begin
      trace_pc    <= pc;
      trace_waddr <= rd;
      trace_wdata <= result;
      trace_wen   <= writes_rd;
    end
  end

endmodule

/* src/blimp_v1.sv */
//--------------------------------------------------------------------------
// blimp v1 top. Memory must return responses in order, one per cycle
// at most, and cannot be stalled by the core.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module blimp_v1 (
  input  logic                               clk,
  input  logic                               rst_n,
  // Instruction memory request
  output logic                               mem_req_val,
  input  logic                               mem_req_rdy,
  output logic [blimp_pkg::XLEN-1:0]          mem_req_addr,
  output logic [blimp_pkg::SEQ_BITS-1:0]      mem_req_opaq,
  // Instruction memory response
  input  logic                               mem_resp_val,
  input  logic [blimp_pkg::XLEN-1:0]          mem_resp_data,
  input  logic [blimp_pkg::SEQ_BITS-1:0]      mem_resp_opaq,
  // Retire trace
  output logic                               trace_val,
  output logic [blimp_pkg::XLEN-1:0]          trace_pc,
  output logic [blimp_pkg::REG_ADDR_BITS-1:0] trace_waddr,
  output logic [blimp_pkg::XLEN-1:0]          trace_wdata,
  output logic                               trace_wen,
  // Sticky tag error
  output logic                               seq_err
);

  import blimp_pkg::*;

  logic [REG_ADDR_BITS-1:0] rs1_addr;
  logic [REG_ADDR_BITS-1:0] rs2_addr;
  logic [XLEN-1:0]          rs1_data;
  logic [XLEN-1:0]          rs2_data;
  logic                     rf_wen;
  logic [REG_ADDR_BITS-1:0] rf_waddr;
  logic [XLEN-1:0]          rf_wdata;

  blimp_fetch i_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req_addr (mem_req_addr),
    .mem_req_opaq (mem_req_opaq),
    .mem_resp_val (mem_resp_val)
  );

  blimp_execute i_execute (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_data (mem_resp_data),
    .mem_resp_opaq (mem_resp_opaq),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .rf_wen        (rf_wen),
    .rf_waddr      (rf_waddr),
    .rf_wdata      (rf_wdata),
    .trace_val     (trace_val),
    .trace_pc      (trace_pc),
    .trace_waddr   (trace_waddr),
    .trace_wdata   (trace_wdata),
    .trace_wen     (trace_wen),
    .seq_err       (seq_err)
  );

  blimp_regfile i_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

endmodule

/* dv/blimp_mem_model.sv */
//--------------------------------------------------------------------------
// Testbench instruction memory. Fixed response latency, in-order returns,
// optional random request stalls and a one-address tag corruption.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module blimp_mem_model (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          stall_en,
  input  logic                          corrupt_tag,
  input  logic [blimp_pkg::XLEN-1:0]     corrupt_addr,
  input  logic                          mem_req_val,
  output logic                          mem_req_rdy,
  input  logic [blimp_pkg::XLEN-1:0]     mem_req_addr,
  input  logic [blimp_pkg::SEQ_BITS-1:0] mem_req_opaq,
  output logic                          mem_resp_val,
  output logic [blimp_pkg::XLEN-1:0]     mem_resp_data,
  output logic [blimp_pkg::SEQ_BITS-1:0] mem_resp_opaq
);

  import blimp_pkg::*;

  localparam int RESP_LATENCY = 2;
  // Percent of cycles with ready held low
  localparam int STALL_PCT    = 40;
  localparam int MEM_WORDS    = 256;
  localparam int IDX_BITS     = $clog2(MEM_WORDS);

  logic [XLEN-1:0]     mem [0:MEM_WORDS-1];
  // Pending responses, oldest first
  logic [XLEN-1:0]     q_data [$];
  logic [SEQ_BITS-1:0] q_tag [$];
  int                  q_due [$];
  int                  cycle;
  integer              seed;
  logic [31:0]         rnd;

  initial begin
    seed          = 32'h88108e1a;
    cycle         = 0;
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_data = '0;
    mem_resp_opaq = '0;
  end

  // Unsupported opcode, upper bits from the word index
  task automatic fill_mem();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {i[24:0], 7'h7f};
    end
  endtask

  task automatic load_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
    mem[addr[IDX_BITS+1:2]] = data;
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (!rst_n) begin
      q_data.delete();
      q_tag.delete();
      q_due.delete();
    end else if (mem_req_val && mem_req_rdy) begin
      q_data.push_back(mem[mem_req_addr[IDX_BITS+1:2]]);
      // Flip bit 0 of the echoed tag for the chosen address
      if (corrupt_tag && (mem_req_addr == corrupt_addr)) begin
        q_tag.push_back({mem_req_opaq[SEQ_BITS-1:1], ~mem_req_opaq[0]});
      end else begin
        q_tag.push_back(mem_req_opaq);
      end
      q_due.push_back(cycle + RESP_LATENCY);
    end
    #1;
    rnd = $random(seed);
    mem_req_rdy = !(stall_en && ((rnd % 100) < STALL_PCT));
    // Driven now, sampled by the core on the due edge
    if ((q_due.size() > 0) && (q_due[0] <= cycle + 1)) begin
      mem_resp_val  = 1'b1;
      mem_resp_data = q_data.pop_front();
      mem_resp_opaq = q_tag.pop_front();
      void'(q_due.pop_front());
    end else begin
      mem_resp_val  = 1'b0;
      mem_resp_data = '0;
      mem_resp_opaq = '0;
    end
  end

endmodule

/* dv/tb_blimp_v1.sv */
//--------------------------------------------------------------------------
// Testbench for blimp v1. Directed programs, each checked trace by trace
// against a shadow register model. Every test starts from a fresh reset.
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_blimp_v1;

  import blimp_pkg::*;

  // Max cycles for any single wait
  localparam int TIMEOUT_CYCLES = 200;

  logic                     clk;
  logic                     rst_n;
  logic                     stall_en;
  logic                     corrupt_tag;
  logic [XLEN-1:0]          corrupt_addr;
  logic                     mem_req_val;
  logic                     mem_req_rdy;
  logic [XLEN-1:0]          mem_req_addr;
  logic [SEQ_BITS-1:0]      mem_req_opaq;
  logic                     mem_resp_val;
  logic [XLEN-1:0]          mem_resp_data;
  logic [SEQ_BITS-1:0]      mem_resp_opaq;
  logic                     trace_val;
  logic [XLEN-1:0]          trace_pc;
  logic [REG_ADDR_BITS-1:0] trace_waddr;
  logic [XLEN-1:0]          trace_wdata;
  logic                     trace_wen;
  logic                     seq_err;

  int                       errors;
  logic [XLEN-1:0]          prog [$];
  logic [XLEN-1:0]          shadow [0:NUM_REGS-1];
  // Expected trace entries with their program index for the seq_err check
  int                       exp_idx [$];
  logic [XLEN-1:0]          exp_pc [$];
  logic [REG_ADDR_BITS-1:0] exp_waddr [$];
  logic [XLEN-1:0]          exp_wdata [$];
  logic                     exp_wen [$];

  blimp_v1 i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_addr  (mem_req_addr),
    .mem_req_opaq  (mem_req_opaq),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_data (mem_resp_data),
    .mem_resp_opaq (mem_resp_opaq),
    .trace_val     (trace_val),
    .trace_pc      (trace_pc),
    .trace_waddr   (trace_waddr),
    .trace_wdata   (trace_wdata),
    .trace_wen     (trace_wen),
    .seq_err       (seq_err)
  );

  blimp_mem_model i_mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_en      (stall_en),
    .corrupt_tag   (corrupt_tag),
    .corrupt_addr  (corrupt_addr),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_addr  (mem_req_addr),
    .mem_req_opaq  (mem_req_opaq),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_data (mem_resp_data),
    .mem_resp_opaq (mem_resp_opaq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //------------------------------------------------------------------------
  // Instruction encoders
  //------------------------------------------------------------------------

  function automatic logic [XLEN-1:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [XLEN-1:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [XLEN-1:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  //------------------------------------------------------------------------
  // Reference model
  //------------------------------------------------------------------------

  // Trace entry for one instruction without touching the shadow regs
  task automatic predict(input logic [XLEN-1:0] insn, output logic [REG_ADDR_BITS-1:0] waddr,
      output logic [XLEN-1:0] wdata, output logic wen);
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic                     known;
    rs1   = insn[19:15];
    rs2   = insn[24:20];
    waddr = insn[11:7];
    wdata = '0;
    known = 1'b1;
    if ((insn[6:0] == OPC_OP) && (insn[14:12] == F3_ADD) && (insn[31:25] == F7_ADD)) begin
      wdata = shadow[rs1] + shadow[rs2];
    end else if ((insn[6:0] == OPC_OP_IMM) && (insn[14:12] == F3_ADD)) begin
      wdata = shadow[rs1] + {{(XLEN-12){insn[31]}}, insn[31:20]};
    end else if (insn[6:0] == OPC_LUI) begin
      wdata = {insn[31:12], 12'h000};
    end else begin
      known = 1'b0;
    end
    // x0 target reports no write
    wen = known && (waddr != 5'd0);
  endtask

  task automatic build_expected(input int drop_idx);
    logic [REG_ADDR_BITS-1:0] waddr;
    logic [XLEN-1:0]          wdata;
    logic                     wen;
    exp_idx.delete();
    exp_pc.delete();
    exp_waddr.delete();
    exp_wdata.delete();
    exp_wen.delete();
    for (int r = 0; r < NUM_REGS; r++) begin
      shadow[r] = '0;
    end
    for (int i = 0; i < prog.size(); i++) begin
      predict(prog[i], waddr, wdata, wen);
      // Dropped instruction neither traces nor writes
      if (i != drop_idx) begin
        exp_idx.push_back(i);
        exp_pc.push_back(RESET_PC + 32'(4 * i));
        exp_waddr.push_back(waddr);
        exp_wdata.push_back(wdata);
        exp_wen.push_back(wen);
        if (wen) begin
          shadow[waddr] = wdata;
        end
      end
    end
  endtask

  //------------------------------------------------------------------------
  // Compare tasks
  //------------------------------------------------------------------------

  task automatic check_word(input string test, input string what,
      input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %h, actual %h", test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_reg(input string test, input string what,
      input logic [REG_ADDR_BITS-1:0] exp, input logic [REG_ADDR_BITS-1:0] act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %0d, actual %0d", test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string test, input string what, input logic exp,
      input logic act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %b, actual %b", test, what, exp, act);
      errors++;
    end
  endtask

  //------------------------------------------------------------------------
  // Sequencing helpers
  //------------------------------------------------------------------------

  // Reset held for 3 cycles while the memory is loaded
  task automatic start_program();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    i_mem.fill_mem();
    for (int i = 0; i < prog.size(); i++) begin
      i_mem.load_word(RESET_PC + 32'(4 * i), prog[i]);
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic wait_trace(input string test, output bit ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++) begin
      @(negedge clk);
      if (trace_val) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      $display("Error in %s: no trace arrived within %0d cycles", test, TIMEOUT_CYCLES);
      errors++;
    end
  endtask

  task automatic run_program(input string test, input int drop_idx);
    bit ok;
    build_expected(drop_idx);
    start_program();
    for (int n = 0; n < exp_pc.size(); n++) begin
      wait_trace(test, ok);
      if (!ok) begin
        return;
      end
      check_word(test, "pc", exp_pc[n], trace_pc);
      check_reg(test, "waddr", exp_waddr[n], trace_waddr);
      check_word(test, "wdata", exp_wdata[n], trace_wdata);
      check_bit(test, "wen", exp_wen[n], trace_wen);
      // Sticky once the dropped instruction has passed
      check_bit(test, "seq_err", (drop_idx >= 0) && (exp_idx[n] > drop_idx), seq_err);
    end
  endtask

  //------------------------------------------------------------------------
  // Programs and tests
  //------------------------------------------------------------------------

  task automatic append_addi_lui();
    prog.push_back(enc_i(12'd5, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM));
    prog.push_back(enc_i(12'hffd, 5'd1, F3_ADD, 5'd2, OPC_OP_IMM));
    prog.push_back(enc_u(20'h12345, 5'd3, OPC_LUI));
    prog.push_back(enc_i(12'h678, 5'd3, F3_ADD, 5'd3, OPC_OP_IMM));
    prog.push_back(enc_i(12'hfff, 5'd0, F3_ADD, 5'd4, OPC_OP_IMM));
    prog.push_back(enc_u(20'hfffff, 5'd5, OPC_LUI));
  endtask

  // Each ADD reads the instruction just before it
  task automatic append_add_chain();
    prog.push_back(enc_i(12'd7, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM));
    prog.push_back(enc_i(12'd9, 5'd0, F3_ADD, 5'd2, OPC_OP_IMM));
    prog.push_back(enc_r(F7_ADD, 5'd2, 5'd1, F3_ADD, 5'd3, OPC_OP));
    prog.push_back(enc_r(F7_ADD, 5'd3, 5'd3, F3_ADD, 5'd4, OPC_OP));
    prog.push_back(enc_r(F7_ADD, 5'd1, 5'd4, F3_ADD, 5'd5, OPC_OP));
    prog.push_back(enc_r(F7_ADD, 5'd5, 5'd5, F3_ADD, 5'd6, OPC_OP));
    prog.push_back(enc_u(20'h80000, 5'd7, OPC_LUI));
    prog.push_back(enc_r(F7_ADD, 5'd6, 5'd7, F3_ADD, 5'd8, OPC_OP));
  endtask

  task automatic test_reset();
    prog.delete();
    append_addi_lui();
    start_program();
    // No edge has seen reset released yet
    @(negedge clk);
    check_bit("reset", "req_val", 1'b0, mem_req_val);
    check_bit("reset", "trace_val", 1'b0, trace_val);
    check_bit("reset", "seq_err", 1'b0, seq_err);
    // First released edge raises the request
    @(negedge clk);
    check_bit("reset", "req_val", 1'b1, mem_req_val);
    check_bit("reset", "trace_val", 1'b0, trace_val);
    check_bit("reset", "seq_err", 1'b0, seq_err);
    check_word("reset", "req_addr", RESET_PC, mem_req_addr);
    check_word("reset", "req_opaq", '0, {{(XLEN-SEQ_BITS){1'b0}}, mem_req_opaq});
  endtask

  task automatic test_addi_lui();
    prog.delete();
    append_addi_lui();
    run_program("addi_lui", -1);
  endtask

  task automatic test_add_chain();
    prog.delete();
    append_add_chain();
    run_program("add_chain", -1);
  endtask

  task automatic test_x0_unsupported();
    prog.delete();
    prog.push_back(enc_i(12'd3, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM));
    prog.push_back(enc_i(12'd5, 5'd1, F3_ADD, 5'd0, OPC_OP_IMM));
    // SUB is outside the decoded set
    prog.push_back(enc_r(7'b0100000, 5'd1, 5'd1, F3_ADD, 5'd6, OPC_OP));
    prog.push_back(enc_i(12'd0, 5'd1, 3'b010, 5'd9, 7'b0000011));
    prog.push_back(enc_i(12'd7, 5'd0, F3_ADD, 5'd5, OPC_OP_IMM));
    prog.push_back(enc_r(F7_ADD, 5'd1, 5'd0, F3_ADD, 5'd6, OPC_OP));
    run_program("x0_unsupported", -1);
  endtask

  task automatic test_stalls();
    prog.delete();
    append_addi_lui();
    append_add_chain();
    @(posedge clk);
    #1;
    stall_en = 1'b1;
    run_program("stalls", -1);
    @(posedge clk);
    #1;
    stall_en = 1'b0;
  endtask

  task automatic test_corrupt();
    prog.delete();
    append_add_chain();
    @(posedge clk);
    #1;
    corrupt_tag  = 1'b1;
    corrupt_addr = RESET_PC + 32'd8;
    run_program("corrupt", 2);
    @(posedge clk);
    #1;
    corrupt_tag = 1'b0;
  endtask

  initial begin
    errors       = 0;
    rst_n        = 1'b0;
    stall_en     = 1'b0;
    corrupt_tag  = 1'b0;
    corrupt_addr = '0;

    test_reset();
    test_addi_lui();
    test_add_chain();
    test_x0_unsupported();
    test_stalls();
    test_corrupt();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* blimp_v1.f */
common/blimp_pkg.sv
fetch/blimp_fetch.sv
src/blimp_regfile.sv
src/blimp_execute.sv
src/blimp_v1.sv
dv/blimp_mem_model.sv
dv/tb_blimp_v1.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the blimp v1 testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_blimp_v1 \
  -f blimp_v1.f \
  -o sim_blimp_v1
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_blimp_v1 > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"
if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  exit 0
fi
exit 1
